// File: riscv_core.f
+incdir+hdl
hdl/riscv_isa_pkg.sv
hdl/riscv_pipe_pkg.sv
hdl/riscv_hazardunit.sv
hdl/riscv_decoder.sv
hdl/riscv_regfile.sv
hdl/riscv_alu.sv
hdl/riscv_pipereg.sv
hdl/riscv_core.sv
verification/riscv_core_tb.sv

// File: Makefile
TOP = riscv_core_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f riscv_core.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then echo "failure reported in sim.log"; exit 1; fi
	@grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f riscv_core.f --top-module riscv_core

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: verification/riscv_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_core_tb;

   localparam int         STORE_TIMEOUT = 300;  // cycles allowed per store
   localparam logic [2:0] K_ADD = 3'd0, K_SUB = 3'd1, K_AND = 3'd2;
   localparam logic [2:0] K_OR = 3'd3, K_XOR = 3'd4, K_SLT = 3'd5;

   logic                   clk;
   logic                   rst_n;
   logic [`RISCV_XLEN-1:0] imem_addr;
   logic [31:0]            imem_instr;
   logic [`RISCV_XLEN-1:0] dmem_addr;
   logic [`RISCV_XLEN-1:0] dmem_wdata;
   logic                   dmem_we;
   logic [`RISCV_XLEN-1:0] dmem_rdata;

   logic [31:0] imem      [0:63];
   logic [31:0] dmem      [0:63];
   logic [31:0] dmem_init [0:63];  // image the reference starts from
   logic [31:0] exp_addr  [$];
   logic [31:0] exp_data  [$];
   logic [31:0] want_addr;
   logic [31:0] want_data;
   string       test_name;
   int          prog_len;
   int          stores_seen;
   logic        checking;
   integer      seed = 32'hc21c;

   riscv_core dut (
      .i_clk        (clk),
      .i_rst_n      (rst_n),
      .o_imem_addr  (imem_addr),
      .i_imem_instr (imem_instr),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_wdata (dmem_wdata),
      .o_dmem_we    (dmem_we),
      .i_dmem_rdata (dmem_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // word-addressed memories with combinational reads
   assign imem_instr = imem[imem_addr[7:2]];
   assign dmem_rdata = rst_n ? dmem[dmem_addr[7:2]] : '0;

   always @(posedge clk)
   begin
      if (!rst_n)
         dmem <= dmem_init;  // fresh image while in reset
      else if (dmem_we)
         dmem[dmem_addr[7:2]] <= dmem_wdata;
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual)
      begin
         $display("ERR %s expected %08h actual %08h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // store compare at mid cycle where the ports are settled
   always @(negedge clk)
   begin
      if (!checking)
         stores_seen = 0;
      else if (dmem_we)
      begin
         if (exp_addr.size() == 0)
         begin
            $display("%s: store to %08h that the program never makes", test_name, dmem_addr);
            $display("Simulation FAILED");
            $fatal(1, "unexpected store");
         end
         else
         begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            check_value({test_name, " store addr"}, want_addr, dmem_addr);
            check_value({test_name, " store data"}, want_data, dmem_wdata);
            stores_seen = stores_seen + 1;
         end
      end
   end

   // instruction encoders
   function automatic logic [31:0] enc_alu(input logic [2:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
      logic [2:0] f3;
      f3 = (op == K_AND) ? 3'b111 : (op == K_OR) ? 3'b110 : (op == K_XOR) ? 3'b100 :
           (op == K_SLT) ? 3'b010 : 3'b000;
      return {1'b0, op == K_SUB, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [11:0] off);
      return {off, 5'd0, 3'b010, rd, 7'b0000011};  // base always x0
   endfunction

   function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] off);
      return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
   endfunction

   task automatic emit(input logic [31:0] instr);
      imem[prog_len] = instr;
      prog_len++;
   endtask

   // ISA interpreter that fills the expected store queues
   function automatic int run_reference(input int max_steps);
      logic [31:0] x   [0:31];
      logic [31:0] mem [0:63];
      logic [31:0] pc, ins, a, b, res, nxt, addr;
      logic [31:0] imm_i, imm_s, imm_b;
      logic        wr;
      for (int r = 0; r < 32; r++)
         x[r] = '0;
      mem = dmem_init;
      pc  = `RISCV_RESET_PC;
      exp_addr.delete();
      exp_data.delete();
      for (int step = 0; step < max_steps; step++)
      begin
         ins   = imem[pc[7:2]];
         a     = x[ins[19:15]];
         b     = x[ins[24:20]];
         imm_i = {{20{ins[31]}}, ins[31:20]};
         imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
         imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
         nxt   = pc + 32'd4;
         wr    = 1'b0;
         res   = '0;
         case (ins[6:0])
            7'b0110011:
            begin
               wr = 1'b1;
               case (ins[14:12])
                  3'b000:  res = ins[30] ? a - b : a + b;
                  3'b111:  res = a & b;
                  3'b110:  res = a | b;
                  3'b100:  res = a ^ b;
                  3'b010:  res = {31'd0, $signed(a) < $signed(b)};
                  default: wr = 1'b0;
               endcase
            end
            7'b0010011:
            begin
               wr  = 1'b1;
               res = a + imm_i;
            end
            7'b0000011:
            begin
               wr   = 1'b1;
               addr = a + imm_i;
               res  = mem[addr[7:2]];
            end
            7'b0100011:
            begin
               addr = a + imm_s;
               exp_addr.push_back(addr);
               exp_data.push_back(b);
               mem[addr[7:2]] = b;
            end
            7'b1100011: if (a == b) nxt = pc + imm_b;
            default: wr = 1'b0;
         endcase
         if (wr && (ins[11:7] != 5'd0))
            x[ins[11:7]] = res;  // x0 stays zero
         if (nxt == pc)
            break;  // self loop ends the program
         pc = nxt;
      end
      return exp_addr.size();
   endfunction

   task automatic wait_store(input int target);
      int cycles;
      cycles = 0;
      while (stores_seen < target)
      begin
         @(posedge clk);
         cycles++;
         if (cycles > STORE_TIMEOUT)
         begin
            $display("%s: core stopped storing after %0d stores", test_name, stores_seen);
            $display("Simulation FAILED");
            $fatal(1, "store timeout");
         end
      end
   endtask

   // reset plus new program space and random data
   task automatic begin_test(input string name);
      @(posedge clk);
      #1;
      rst_n     = 1'b0;
      checking  = 1'b0;
      test_name = name;
      for (int i = 0; i < 64; i++)
      begin
         imem[i]      = enc_addi(5'd0, 5'd0, 12'(i));  // harmless filler unique per word
         dmem_init[i] = $random(seed);
      end
      prog_len = 0;
   endtask

   task automatic finish_test();
      int n_exp;
      emit(enc_beq(5'd0, 5'd0, 13'd0));  // park here
      n_exp = run_reference(500);
      repeat (8) @(posedge clk);
      #1;
      check_value({test_name, " reset pc"}, `RISCV_RESET_PC, imem_addr);
      check_value({test_name, " reset dmem we"}, 32'd0, {31'd0, dmem_we});
      rst_n    = 1'b1;
      checking = 1'b1;
      for (int k = 1; k <= n_exp; k++)
         wait_store(k);
      repeat (20) @(posedge clk);  // stray stores would be caught here
      #1;
      checking = 1'b0;
      $display("%s: %0d stores matched", test_name, n_exp);
   endtask

   task automatic random_program(input int body_len);
      logic [31:0] rnd;
      for (int i = 0; i < body_len; i++)
      begin
         rnd = $random(seed);
         case (rnd[3:0])
            4'd6, 4'd7, 4'd13: emit(enc_addi({2'b0, rnd[6:4]}, {2'b0, rnd[9:7]}, rnd[24:13]));
            4'd8, 4'd9:        emit(enc_lw({2'b0, rnd[6:4]}, {4'd0, rnd[18:13], 2'b00}));
            4'd10, 4'd11:      emit(enc_sw({2'b0, rnd[12:10]}, {4'd0, rnd[18:13], 2'b00}));
            4'd12:             emit(enc_beq({2'b0, rnd[9:7]}, {2'b0, rnd[12:10]},
                                            {8'd0, 3'(rnd[14:13]) + 3'd1, 2'b00}));
            4'd14, 4'd15:      emit(enc_alu(K_SUB, {2'b0, rnd[6:4]}, {2'b0, rnd[9:7]},
                                            {2'b0, rnd[12:10]}));
            default:           emit(enc_alu(rnd[2:0], {2'b0, rnd[6:4]}, {2'b0, rnd[9:7]},
                                            {2'b0, rnd[12:10]}));
         endcase
      end
      for (int r = 1; r < 8; r++)
         emit(enc_sw(5'(r), 12'(200 + 4 * r)));  // dump x1..x7
   endtask

   initial
   begin
      rst_n       = 1'b0;
      checking    = 1'b0;
      prog_len    = 0;
      for (int i = 0; i < 64; i++)
      begin
         imem[i]      = enc_addi(5'd0, 5'd0, 12'(i));
         dmem_init[i] = ~(32'(i) * 32'h0101_0101);
      end

      begin_test("mem_forward");
      emit(enc_addi(5'd1, 5'd0, 12'd5));
      emit(enc_addi(5'd2, 5'd1, 12'd7));      // x1 from memory stage
      emit(enc_alu(K_ADD, 5'd3, 5'd2, 5'd1));
      emit(enc_alu(K_SUB, 5'd4, 5'd3, 5'd2));
      emit(enc_sw(5'd4, 12'd0));              // store data forwarded
      emit(enc_sw(5'd3, 12'd4));
      finish_test();

      begin_test("wb_forward");
      emit(enc_addi(5'd5, 5'd0, 12'd100));
      emit(enc_addi(5'd6, 5'd0, -12'd200));
      emit(enc_alu(K_XOR, 5'd7, 5'd5, 5'd0)); // two apart
      emit(enc_alu(K_OR, 5'd8, 5'd6, 5'd5));  // x5 three apart via write-through
      emit(enc_alu(K_AND, 5'd9, 5'd7, 5'd8));
      emit(enc_alu(K_SLT, 5'd10, 5'd6, 5'd5));
      emit(enc_sw(5'd9, 12'd8));
      emit(enc_sw(5'd10, 12'd12));
      emit(enc_sw(5'd8, 12'd16));
      finish_test();

      begin_test("load_use");
      emit(enc_lw(5'd1, 12'd20));
      emit(enc_alu(K_ADD, 5'd2, 5'd1, 5'd1)); // stall on rs1
      emit(enc_sw(5'd2, 12'd24));
      emit(enc_lw(5'd3, 12'd24));             // reads the fresh store
      emit(enc_sw(5'd3, 12'd28));             // stall on rs2
      finish_test();

      begin_test("branch");
      emit(enc_addi(5'd1, 5'd0, 12'd9));
      emit(enc_addi(5'd2, 5'd0, 12'd9));
      emit(enc_addi(5'd3, 5'd0, 12'd4));
      emit(enc_beq(5'd1, 5'd3, 13'd12));      // not taken
      emit(enc_sw(5'd1, 12'd32));
      emit(enc_sw(5'd3, 12'd36));
      emit(enc_beq(5'd1, 5'd2, 13'd12));      // taken with two shadow stores
      emit(enc_sw(5'd1, 12'd40));
      emit(enc_sw(5'd2, 12'd44));
      emit(enc_sw(5'd2, 12'd48));
      finish_test();

      begin_test("x0_const");
      emit(enc_addi(5'd1, 5'd0, 12'd77));
      emit(enc_addi(5'd0, 5'd0, 12'd55));     // dropped write
      emit(enc_alu(K_ADD, 5'd2, 5'd0, 5'd1));
      emit(enc_sw(5'd2, 12'd52));
      emit(enc_alu(K_ADD, 5'd0, 5'd1, 5'd1));
      emit(enc_sw(5'd0, 12'd56));
      finish_test();

      begin_test("random_mix");
      random_program(48);
      finish_test();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hdl/riscv_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_core
   import riscv_isa_pkg::*;
   import riscv_pipe_pkg::*;
(
   input  logic                   i_clk,
   input  logic                   i_rst_n,
   output logic [`RISCV_XLEN-1:0] o_imem_addr,
   input  logic [31:0]            i_imem_instr,   // combinational read
   output logic [`RISCV_XLEN-1:0] o_dmem_addr,
   output logic [`RISCV_XLEN-1:0] o_dmem_wdata,
   output logic                   o_dmem_we,
   input  logic [`RISCV_XLEN-1:0] i_dmem_rdata
);

   logic [`RISCV_XLEN-1:0]   pc_q;
   logic [`RISCV_XLEN-1:0]   pc_next;
   fd_t                      fd_d, fd_q;
   de_t                      de_d, de_q;
   em_t                      em_d, em_q;
   mw_t                      mw_d, mw_q;
   ctrl_t                    dec_ctrl;
   logic [`RISCV_XLEN-1:0]   dec_imm;
   logic [`RISCV_REGA_W-1:0] dec_rs1, dec_rs2, dec_rd;
   logic [`RISCV_XLEN-1:0]   rf_rdata1, rf_rdata2;
   hzrd_in_t                 hz_in;
   fwd_sel_t                 hz_fwda, hz_fwdb;
   logic                     hz_stall, hz_flushfd, hz_flushde;
   logic [`RISCV_XLEN-1:0]   src_a, fwd_b, src_b;
   logic [`RISCV_XLEN-1:0]   alu_result;
   logic                     alu_zero;
   logic                     pcsrc_e;
   logic [`RISCV_XLEN-1:0]   wb_result;

   // execute operand pick, mem result never a load here thanks to the stall
   function automatic logic [`RISCV_XLEN-1:0] fwd_mux(input fwd_sel_t sel,
                                                      input logic [`RISCV_XLEN-1:0] rf_val,
                                                      input logic [`RISCV_XLEN-1:0] mem_val,
                                                      input logic [`RISCV_XLEN-1:0] wb_val);
      case (sel)
         FWD_FROM_MEM: return mem_val;
         FWD_FROM_WB:  return wb_val;
         default:      return rf_val;
      endcase
   endfunction

   // fetch
   assign pcsrc_e = de_q.ctrl.branch & alu_zero;  // beq resolves in execute
   assign pc_next = pcsrc_e ? (de_q.pc + de_q.imm) : (pc_q + `RISCV_XLEN'd4);

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         pc_q <= `RISCV_RESET_PC;
      else if (!hz_stall)  // load-use holds fetch
         pc_q <= pc_next;
   end

   assign o_imem_addr = pc_q;
   assign fd_d        = '{pc: pc_q, instr: i_imem_instr};

   riscv_pipereg #(.T_PAYLOAD(fd_t)) u_fd_reg (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_riscv_pr_stall (hz_stall),
      .i_riscv_pr_flush (hz_flushfd),
      .i_riscv_pr_d     (fd_d),
      .o_riscv_pr_q     (fd_q)
   );

   // decode
   riscv_decoder u_decoder (
      .i_riscv_dec_instr   (fd_q.instr),
      .o_riscv_dec_ctrl    (dec_ctrl),
      .o_riscv_dec_imm     (dec_imm),
      .o_riscv_dec_rs1addr (dec_rs1),
      .o_riscv_dec_rs2addr (dec_rs2),
      .o_riscv_dec_rdaddr  (dec_rd)
   );

   riscv_regfile u_regfile (
      .i_clk             (i_clk),
      .i_rst_n           (i_rst_n),
      .i_riscv_rf_we     (mw_q.ctrl.reg_write),  // written from writeback
      .i_riscv_rf_waddr  (mw_q.rd),
      .i_riscv_rf_wdata  (wb_result),
      .i_riscv_rf_raddr1 (dec_rs1),
      .i_riscv_rf_raddr2 (dec_rs2),
      .o_riscv_rf_rdata1 (rf_rdata1),
      .o_riscv_rf_rdata2 (rf_rdata2)
   );

   assign de_d = '{ctrl: dec_ctrl, pc: fd_q.pc, rs1_val: rf_rdata1, rs2_val: rf_rdata2,
                   rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd, imm: dec_imm};

   riscv_pipereg #(.T_PAYLOAD(de_t)) u_de_reg (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_riscv_pr_stall (1'b0),
      .i_riscv_pr_flush (hz_flushde),  // branch or load-use bubble
      .i_riscv_pr_d     (de_d),
      .o_riscv_pr_q     (de_q)
   );

   // execute
   assign src_a = fwd_mux(hz_fwda, de_q.rs1_val, em_q.alu_result, wb_result);
   assign fwd_b = fwd_mux(hz_fwdb, de_q.rs2_val, em_q.alu_result, wb_result);
   assign src_b = de_q.ctrl.alu_src_imm ? de_q.imm : fwd_b;

   riscv_alu u_alu (
      .i_riscv_alu_op     (de_q.ctrl.alu_op),
      .i_riscv_alu_a      (src_a),
      .i_riscv_alu_b      (src_b),
      .o_riscv_alu_result (alu_result),
      .o_riscv_alu_zero   (alu_zero)
   );

   assign em_d = '{ctrl: de_q.ctrl, alu_result: alu_result, store_data: fwd_b, rd: de_q.rd};

   riscv_pipereg #(.T_PAYLOAD(em_t)) u_em_reg (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_riscv_pr_stall (1'b0),
      .i_riscv_pr_flush (1'b0),
      .i_riscv_pr_d     (em_d),
      .o_riscv_pr_q     (em_q)
   );

   // memory
   assign o_dmem_addr  = em_q.alu_result;
   assign o_dmem_wdata = em_q.store_data;
   assign o_dmem_we    = em_q.ctrl.mem_write;
   assign mw_d = '{ctrl: em_q.ctrl, alu_result: em_q.alu_result, load_data: i_dmem_rdata,
                   rd: em_q.rd};

   riscv_pipereg #(.T_PAYLOAD(mw_t)) u_mw_reg (
      .i_clk            (i_clk),
      .i_rst_n          (i_rst_n),
      .i_riscv_pr_stall (1'b0),
      .i_riscv_pr_flush (1'b0),
      .i_riscv_pr_d     (mw_d),
      .o_riscv_pr_q     (mw_q)
   );

   // writeback
   assign wb_result = (mw_q.ctrl.result_src == RES_MEM) ? mw_q.load_data : mw_q.alu_result;

   // hazard unit
   assign hz_in = '{rs1_d: dec_rs1, rs2_d: dec_rs2, rs1_e: de_q.rs1, rs2_e: de_q.rs2,
                    rd_e: de_q.rd, result_src_e: de_q.ctrl.result_src,
                    rd_m: em_q.rd, reg_write_m: em_q.ctrl.reg_write,
                    rd_w: mw_q.rd, reg_write_w: mw_q.ctrl.reg_write, pcsrc_e: pcsrc_e};

   riscv_hazardunit u_hazardunit (
      .i_riscv_hzrdu_in      (hz_in),
      .o_riscv_hzrdu_fwda    (hz_fwda),
      .o_riscv_hzrdu_fwdb    (hz_fwdb),
      .o_riscv_hzrdu_stall   (hz_stall),
      .o_riscv_hzrdu_flushfd (hz_flushfd),
      .o_riscv_hzrdu_flushde (hz_flushde)
   );

   // the injected bubble clears the load-use condition
   a_stall_one_cycle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      hz_stall |=> !hz_stall)
      else $error("load-use stall lasted more than one cycle");

endmodule

`default_nettype wire

// File: hdl/riscv_pipereg.sv
`timescale 1ns/1ns
`default_nettype none

// one stage register, payload type chosen per stage
module riscv_pipereg #(
   parameter type T_PAYLOAD = logic
)
(
   input  logic     i_clk,
   input  logic     i_rst_n,
   input  logic     i_riscv_pr_stall,
   input  logic     i_riscv_pr_flush,  // beats stall
   input  T_PAYLOAD i_riscv_pr_d,
   output T_PAYLOAD o_riscv_pr_q
);

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
         o_riscv_pr_q <= '0;  // start out as bubbles
      else if (i_riscv_pr_flush)
         o_riscv_pr_q <= '0;  // zero ctrl means no reg or mem write
      else if (!i_riscv_pr_stall)
         o_riscv_pr_q <= i_riscv_pr_d;
   end

   a_flush_bubble : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_riscv_pr_flush |=> (o_riscv_pr_q == '0))
      else $error("stage register not a bubble after flush");

endmodule

`default_nettype wire

// File: hdl/riscv_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_alu
   import riscv_isa_pkg::*;
(
   input  alu_op_t                i_riscv_alu_op,
   input  logic [`RISCV_XLEN-1:0] i_riscv_alu_a,
   input  logic [`RISCV_XLEN-1:0] i_riscv_alu_b,
   output logic [`RISCV_XLEN-1:0] o_riscv_alu_result,
   output logic                   o_riscv_alu_zero     // beq taken when sub gives 0
);

   always_comb
   begin
      case (i_riscv_alu_op)
         ALU_ADD: o_riscv_alu_result = i_riscv_alu_a + i_riscv_alu_b;
         ALU_SUB: o_riscv_alu_result = i_riscv_alu_a - i_riscv_alu_b;
         ALU_AND: o_riscv_alu_result = i_riscv_alu_a & i_riscv_alu_b;
         ALU_OR:  o_riscv_alu_result = i_riscv_alu_a | i_riscv_alu_b;
         ALU_XOR: o_riscv_alu_result = i_riscv_alu_a ^ i_riscv_alu_b;
         ALU_SLT: o_riscv_alu_result = {{(`RISCV_XLEN-1){1'b0}},                 // signed compare
                                        $signed(i_riscv_alu_a) < $signed(i_riscv_alu_b)};
         default: o_riscv_alu_result = '0;
      endcase
   end

   assign o_riscv_alu_zero = (o_riscv_alu_result == '0);

endmodule

`default_nettype wire

// File: hdl/riscv_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_regfile
(
   input  logic                     i_clk,
   input  logic                     i_rst_n,
   input  logic                     i_riscv_rf_we,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_rf_waddr,
   input  logic [`RISCV_XLEN-1:0]   i_riscv_rf_wdata,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_rf_raddr1,
   input  logic [`RISCV_REGA_W-1:0] i_riscv_rf_raddr2,
   output logic [`RISCV_XLEN-1:0]   o_riscv_rf_rdata1,
   output logic [`RISCV_XLEN-1:0]   o_riscv_rf_rdata2
);

   logic [`RISCV_XLEN-1:0] regs [1:31];  // no storage for x0

   // x0 reads zero, same-cycle writeback is passed straight through
   function automatic logic [`RISCV_XLEN-1:0] read_port(input logic [`RISCV_REGA_W-1:0] addr);
      if (addr == '0)
         return '0;
      else if (i_riscv_rf_we && (i_riscv_rf_waddr == addr))
         return i_riscv_rf_wdata;
      else
         return regs[addr];
   endfunction

   always_ff @(posedge i_clk or negedge i_rst_n)
   begin
      if (!i_rst_n)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end
      else if (i_riscv_rf_we && (i_riscv_rf_waddr != '0))  // writes to x0 dropped
         regs[i_riscv_rf_waddr] <= i_riscv_rf_wdata;
   end

   always_comb
   begin
      o_riscv_rf_rdata1 = read_port(i_riscv_rf_raddr1);
      o_riscv_rf_rdata2 = read_port(i_riscv_rf_raddr2);
   end

endmodule

`default_nettype wire

// File: hdl/riscv_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

module riscv_decoder
   import riscv_isa_pkg::*;
(
   input  logic [31:0]              i_riscv_dec_instr,
   output ctrl_t                    o_riscv_dec_ctrl,
   output logic [`RISCV_XLEN-1:0]   o_riscv_dec_imm,
   output logic [`RISCV_REGA_W-1:0] o_riscv_dec_rs1addr,
   output logic [`RISCV_REGA_W-1:0] o_riscv_dec_rs2addr,
   output logic [`RISCV_REGA_W-1:0] o_riscv_dec_rdaddr
);

   opcode_t                opcode;
   logic [2:0]             funct3;
   logic                   funct7b5;  // sub vs add
   logic [`RISCV_XLEN-1:0] imm_i;
   logic [`RISCV_XLEN-1:0] imm_s;
   logic [`RISCV_XLEN-1:0] imm_b;

   assign opcode   = opcode_t'(i_riscv_dec_instr[6:0]);
   assign funct3   = i_riscv_dec_instr[14:12];
   assign funct7b5 = i_riscv_dec_instr[30];

   // fixed field positions, fields read even when unused
   assign o_riscv_dec_rs1addr = i_riscv_dec_instr[19:15];
   assign o_riscv_dec_rs2addr = i_riscv_dec_instr[24:20];
   assign o_riscv_dec_rdaddr  = i_riscv_dec_instr[11:7];

   // sign-extended immediates
   assign imm_i = {{(`RISCV_XLEN-12){i_riscv_dec_instr[31]}}, i_riscv_dec_instr[31:20]};
   assign imm_s = {{(`RISCV_XLEN-12){i_riscv_dec_instr[31]}},
                   i_riscv_dec_instr[31:25], i_riscv_dec_instr[11:7]};
   assign imm_b = {{(`RISCV_XLEN-12){i_riscv_dec_instr[31]}}, i_riscv_dec_instr[7],
                   i_riscv_dec_instr[30:25], i_riscv_dec_instr[11:8], 1'b0};  // lsb always 0

   always_comb
   begin
      o_riscv_dec_ctrl = '0;  // bubble unless recognised
      o_riscv_dec_imm  = '0;
      case (opcode)
         OP_R:
         begin
            o_riscv_dec_ctrl.reg_write = 1'b1;
            case (funct3)
               3'b000:  o_riscv_dec_ctrl.alu_op = funct7b5 ? ALU_SUB : ALU_ADD;
               3'b111:  o_riscv_dec_ctrl.alu_op = ALU_AND;
               3'b110:  o_riscv_dec_ctrl.alu_op = ALU_OR;
               3'b100:  o_riscv_dec_ctrl.alu_op = ALU_XOR;
               3'b010:  o_riscv_dec_ctrl.alu_op = ALU_SLT;
               default: o_riscv_dec_ctrl = '0;  // sll, srl etc. not built
            endcase
         end
         OP_I:
         begin
            o_riscv_dec_imm = imm_i;
            if (funct3 == 3'b000)  // addi
            begin
               o_riscv_dec_ctrl.reg_write   = 1'b1;
               o_riscv_dec_ctrl.alu_src_imm = 1'b1;
            end
         end
         OP_LOAD:
         begin
            o_riscv_dec_imm = imm_i;
            if (funct3 == 3'b010)  // lw only
            begin
               o_riscv_dec_ctrl.reg_write   = 1'b1;
               o_riscv_dec_ctrl.alu_src_imm = 1'b1;
               o_riscv_dec_ctrl.result_src  = RES_MEM;
            end
         end
         OP_STORE:
         begin
            o_riscv_dec_imm = imm_s;
            if (funct3 == 3'b010)  // sw only
            begin
               o_riscv_dec_ctrl.mem_write   = 1'b1;
               o_riscv_dec_ctrl.alu_src_imm = 1'b1;
            end
         end
         OP_BRANCH:
         begin
            o_riscv_dec_imm = imm_b;
            if (funct3 == 3'b000)  // beq, compare by subtract
            begin
               o_riscv_dec_ctrl.branch = 1'b1;
               o_riscv_dec_ctrl.alu_op = ALU_SUB;
            end
         end
         default: o_riscv_dec_ctrl = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/riscv_hazardunit.sv
`timescale 1ns/1ns
`default_nettype none

`include "riscv_macros.svh"

// purely combinational, no clock
module riscv_hazardunit
   import riscv_isa_pkg::*;
   import riscv_pipe_pkg::*;
(
   input  hzrd_in_t i_riscv_hzrdu_in,
   output fwd_sel_t o_riscv_hzrdu_fwda,
   output fwd_sel_t o_riscv_hzrdu_fwdb,
   output logic     o_riscv_hzrdu_stall,    // hold pc and fetch/decode
   output logic     o_riscv_hzrdu_flushfd,
   output logic     o_riscv_hzrdu_flushde
);

   logic lw_stall;

   // priority mux, memory stage is the younger result
   function automatic fwd_sel_t pick_fwd(input logic [`RISCV_REGA_W-1:0] src,
                                         input hzrd_in_t h);
      if (h.reg_write_m && (h.rd_m != '0) && (h.rd_m == src))
         return FWD_FROM_MEM;
      else if (h.reg_write_w && (h.rd_w != '0) && (h.rd_w == src))
         return FWD_FROM_WB;
      else
         return FWD_NONE;
   endfunction

   assign o_riscv_hzrdu_fwda = pick_fwd(i_riscv_hzrdu_in.rs1_e, i_riscv_hzrdu_in);
   assign o_riscv_hzrdu_fwdb = pick_fwd(i_riscv_hzrdu_in.rs2_e, i_riscv_hzrdu_in);

   // load in execute feeding the instr in decode
   assign lw_stall = (i_riscv_hzrdu_in.result_src_e == RES_MEM) &&
                     ((i_riscv_hzrdu_in.rs1_d == i_riscv_hzrdu_in.rd_e) ||
                      (i_riscv_hzrdu_in.rs2_d == i_riscv_hzrdu_in.rd_e));

   assign o_riscv_hzrdu_stall   = lw_stall;
   assign o_riscv_hzrdu_flushfd = i_riscv_hzrdu_in.pcsrc_e;              // wrong-path fetch
   assign o_riscv_hzrdu_flushde = i_riscv_hzrdu_in.pcsrc_e | lw_stall;  // bubble into execute

   // x0 is constant, a forward would leak a stale write
   always_comb
   begin
      assert final ((i_riscv_hzrdu_in.rs1_e != '0) || (o_riscv_hzrdu_fwda == FWD_NONE))
         else $error("hazard unit forwards into x0 on rs1");
      assert final ((i_riscv_hzrdu_in.rs2_e != '0) || (o_riscv_hzrdu_fwdb == FWD_NONE))
         else $error("hazard unit forwards into x0 on rs2");
   end

endmodule

`default_nettype wire

// File: hdl/riscv_pipe_pkg.sv
`default_nettype none

`include "riscv_macros.svh"

package riscv_pipe_pkg;
   import riscv_isa_pkg::*;

   // select codes decoded by the execute forwarding muxes
   typedef enum logic [1:0] {
      FWD_NONE     = 2'd0,
      FWD_FROM_MEM = 2'd1,
      FWD_FROM_WB  = 2'd2
   } fwd_sel_t;

   // fetch -> decode
   typedef struct packed {
      logic [`RISCV_XLEN-1:0] pc;
      logic [31:0]            instr;
   } fd_t;

   // decode -> execute
   typedef struct packed {
      ctrl_t                    ctrl;
      logic [`RISCV_XLEN-1:0]   pc;
      logic [`RISCV_XLEN-1:0]   rs1_val;
      logic [`RISCV_XLEN-1:0]   rs2_val;
      logic [`RISCV_REGA_W-1:0] rs1;
      logic [`RISCV_REGA_W-1:0] rs2;
      logic [`RISCV_REGA_W-1:0] rd;
      logic [`RISCV_XLEN-1:0]   imm;
   } de_t;

   // execute -> memory
   typedef struct packed {
      ctrl_t                    ctrl;
      logic [`RISCV_XLEN-1:0]   alu_result;  // also the dmem address
      logic [`RISCV_XLEN-1:0]   store_data;  // forwarded rs2
      logic [`RISCV_REGA_W-1:0] rd;
   } em_t;

   // memory -> writeback
   typedef struct packed {
      ctrl_t                    ctrl;
      logic [`RISCV_XLEN-1:0]   alu_result;
      logic [`RISCV_XLEN-1:0]   load_data;
      logic [`RISCV_REGA_W-1:0] rd;
   } mw_t;

   // everything the hazard unit looks at
   typedef struct packed {
      logic [`RISCV_REGA_W-1:0] rs1_d;
      logic [`RISCV_REGA_W-1:0] rs2_d;
      logic [`RISCV_REGA_W-1:0] rs1_e;
      logic [`RISCV_REGA_W-1:0] rs2_e;
      logic [`RISCV_REGA_W-1:0] rd_e;
      result_src_t              result_src_e;
      logic [`RISCV_REGA_W-1:0] rd_m;
      logic                     reg_write_m;
      logic [`RISCV_REGA_W-1:0] rd_w;
      logic                     reg_write_w;
      logic                     pcsrc_e;       // taken beq in execute
   } hzrd_in_t;

endpackage

`default_nettype wire

// File: hdl/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OP_R      = 7'b0110011,  // add sub and or xor slt
      OP_I      = 7'b0010011,  // addi only
      OP_LOAD   = 7'b0000011,  // lw
      OP_STORE  = 7'b0100011,  // sw
      OP_BRANCH = 7'b1100011   // beq
   } opcode_t;

   // add is 0 so an all-zero ctrl is a harmless add
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLT = 3'd5
   } alu_op_t;

   // 2'b10 marks a load, hazard unit keys on it
   typedef enum logic [1:0] {
      RES_ALU = 2'b00,
      RES_MEM = 2'b10
   } result_src_t;

   // decoded controls, all zero is a bubble
   typedef struct packed {
      logic        reg_write;
      logic        mem_write;
      logic        branch;       // beq
      logic        alu_src_imm;  // b operand from imm
      alu_op_t     alu_op;
      result_src_t result_src;
   } ctrl_t;

endpackage

`default_nettype wire

// File: hdl/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath width
`define RISCV_XLEN 32

// x0..x31
`define RISCV_REGA_W 5

// first fetch after reset
`define RISCV_RESET_PC 32'h0000_0000

`endif
